// ==== Bender.yml ====
package:
  name: l2_mshr

export_include_dirs:
  - common

sources:
  - common/coh_pkg.sv
  - common/mshr_pkg.sv
  - mshr/mshr_entry.sv
  - mshr/mshr_search.sv
  - mshr/mshr_top.sv
  - target: test
    files:
      - test/tb_mshr.sv

// ==== common/coh_pkg.sv ====
package coh_pkg;

    // transient states kept in an mshr entry
    // SPX_I marks the slot as free
    typedef enum logic [2:0] {
        SPX_I   = 3'd0,
        SPX_IS  = 3'd1,
        SPX_II  = 3'd2,
        SPX_RI  = 3'd3,
        SPX_XR  = 3'd4,
        SPX_XRV = 3'd5,
        SPX_AMO = 3'd6
    } spx_state_t;

    // forwarded coherence messages from the directory
    typedef enum logic [2:0] {
        FWD_INV       = 3'd0,
        FWD_RVK_O     = 3'd1,
        FWD_REQ_S     = 3'd2,
        FWD_REQ_ODATA = 3'd3,
        FWD_REQ_V     = 3'd4
    } fwd_msg_t;

    // operations the controller FSM asks of the mshr file
    typedef enum logic [2:0] {
        MSHR_IDLE       = 3'd0,
        MSHR_LOOKUP     = 3'd1,
        MSHR_PEEK_REQ   = 3'd2,
        MSHR_PEEK_FLUSH = 3'd3,
        MSHR_PEEK_FWD   = 3'd4
    } mshr_op_t;

endpackage

// ==== common/l2_macros.svh ====
`ifndef L2_MACROS_SVH
`define L2_MACROS_SVH

// mshr file depth and index width
`define N_MSHR 4
`define MSHR_BITS 2

// line address split
`define TAG_BITS 8
`define SET_BITS 4
`define W_OFF_BITS 2
`define WAY_BITS 2

// data widths, one bit of word mask per word
`define WORDS_PER_LINE 4
`define WORD_BITS 32
`define LINE_BITS (`WORDS_PER_LINE * `WORD_BITS)

`endif

// ==== common/mshr_pkg.sv ====
`include "l2_macros.svh"

package mshr_pkg;

    // cpu request address, byte offset already stripped
    typedef struct packed {
        logic [`TAG_BITS-1:0]   tag;
        logic [`SET_BITS-1:0]   set;
        logic [`W_OFF_BITS-1:0] w_off;
    } req_addr_t;

    // line address used for lookups and forwards
    typedef struct packed {
        logic [`TAG_BITS-1:0] tag;
        logic [`SET_BITS-1:0] set;
    } line_addr_t;

    // write data broadcast to every entry
    typedef struct packed {
        logic [1:0]                cpu_msg;
        logic [`WAY_BITS-1:0]      way;
        logic [`WORD_BITS-1:0]     word;
        coh_pkg::spx_state_t       state;
        logic [`LINE_BITS-1:0]     line;
        logic [`TAG_BITS-1:0]      tag;
        logic [`WORDS_PER_LINE-1:0] word_mask;
    } mshr_wr_t;

    // stored entry, set and w_off come from the request address
    typedef struct packed {
        logic [1:0]                cpu_msg;
        logic [`SET_BITS-1:0]      set;
        logic [`WAY_BITS-1:0]      way;
        logic [`W_OFF_BITS-1:0]    w_off;
        logic [`WORD_BITS-1:0]     word;
        coh_pkg::spx_state_t       state;
        logic [`LINE_BITS-1:0]     line;
        logic [`TAG_BITS-1:0]      tag;
        logic [`WORDS_PER_LINE-1:0] word_mask;
    } mshr_entry_t;

    // per-entry status seen by the search
    typedef struct packed {
        logic valid;
        logic line_match;
        logic set_match;
        logic wr_pending;
        logic fwd_ok;
    } entry_flags_t;

endpackage

// ==== files.f ====
+incdir+common
common/coh_pkg.sv
common/mshr_pkg.sv
mshr/mshr_entry.sv
mshr/mshr_search.sv
mshr/mshr_top.sv
test/tb_mshr.sv

// ==== mshr/mshr_entry.sv ====
`timescale 1ns/1ns
`include "l2_macros.svh"

module mshr_entry #(
    parameter int unsigned ENTRY_ID = 0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   add_entry_i,
    input  logic                   upd_state_i,
    input  logic                   upd_line_i,
    input  logic                   upd_tag_i,
    input  logic                   upd_mask_i,
    input  logic [`MSHR_BITS-1:0]  wr_idx_i,
    input  mshr_pkg::req_addr_t    req_addr_i,
    input  mshr_pkg::mshr_wr_t     wr_data_i,
    input  mshr_pkg::line_addr_t   line_addr_i,
    input  coh_pkg::fwd_msg_t      fwd_msg_i,
    output mshr_pkg::mshr_entry_t  entry_o,
    output mshr_pkg::entry_flags_t flags_o
);
    import coh_pkg::*;

    // own slot number, sized to the index
    localparam logic [`MSHR_BITS-1:0] SLOT = ENTRY_ID[`MSHR_BITS-1:0];

    logic sel;
    logic valid;

    // this slot is the one the registered index points at
    assign sel = (wr_idx_i == SLOT);

    // request payload, only written on add
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            entry_o.cpu_msg <= '0;
            entry_o.set     <= '0;
            entry_o.way     <= '0;
            entry_o.w_off   <= '0;
            entry_o.word    <= '0;
        end else if (sel && add_entry_i) begin
            entry_o.cpu_msg <= wr_data_i.cpu_msg;
            entry_o.set     <= req_addr_i.set;
            entry_o.way     <= wr_data_i.way;
            entry_o.w_off   <= req_addr_i.w_off;
            entry_o.word    <= wr_data_i.word;
        end
    end

    // state, line, tag and mask each have their own enable
    // add writes all of them at once
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            entry_o.state     <= SPX_I;
            entry_o.line      <= '0;
            entry_o.tag       <= '0;
            entry_o.word_mask <= '0;
        end else if (sel) begin
            if (add_entry_i || upd_state_i) begin
                entry_o.state <= wr_data_i.state;
            end
            if (add_entry_i || upd_line_i) begin
                entry_o.line <= wr_data_i.line;
            end
            if (add_entry_i || upd_tag_i) begin
                entry_o.tag <= wr_data_i.tag;
            end
            if (add_entry_i || upd_mask_i) begin
                entry_o.word_mask <= wr_data_i.word_mask;
            end
        end
    end

    assign valid = (entry_o.state != SPX_I);

    always_comb begin
        flags_o.valid      = valid;
        flags_o.line_match = valid && (entry_o.tag == line_addr_i.tag)
                             && (entry_o.set == line_addr_i.set);
        flags_o.set_match  = valid && (entry_o.set == req_addr_i.set);
        // waiting for ownership or an atomic
        flags_o.wr_pending = (entry_o.state inside {SPX_XR, SPX_XRV, SPX_AMO});
        // forward may go ahead without a stall
        flags_o.fwd_ok     = 1'b0;
        case (fwd_msg_i)
            FWD_INV: flags_o.fwd_ok = 1'b1;
            FWD_RVK_O, FWD_REQ_S, FWD_REQ_ODATA: flags_o.fwd_ok = (entry_o.state == SPX_RI);
            default: flags_o.fwd_ok = 1'b0;
        endcase
    end

    // a partial update needs a live entry unless add comes with it
    a_upd_live: assert property (@(posedge clk) disable iff (!rst)
        sel && !add_entry_i && (upd_state_i || upd_line_i || upd_tag_i || upd_mask_i)
        |-> valid);

endmodule

// ==== mshr/mshr_search.sv ====
`timescale 1ns/1ns
`include "l2_macros.svh"

module mshr_search (
    input  logic                   clk,
    input  logic                   rst,
    input  coh_pkg::mshr_op_t      op_i,
    input  mshr_pkg::entry_flags_t flags_i [`N_MSHR],
    output logic                   hit_next_o,
    output logic                   hit_o,
    output logic [`MSHR_BITS-1:0]  idx_next_o,
    output logic [`MSHR_BITS-1:0]  idx_o,
    output logic                   set_conflict_set_o,
    output logic                   set_conflict_clr_o,
    output logic                   fwd_stall_set_o,
    output logic                   fwd_stall_clr_o,
    output logic                   fwd_stall_entry_set_o,
    output logic [`MSHR_BITS-1:0]  fwd_stall_entry_o,
    output logic                   write_pending_o
);
    import coh_pkg::*;

    // priority scan, later slots overwrite earlier ones
    always_comb begin
        hit_next_o            = 1'b0;
        idx_next_o            = '0;
        set_conflict_set_o    = 1'b0;
        set_conflict_clr_o    = 1'b0;
        fwd_stall_set_o       = 1'b0;
        fwd_stall_clr_o       = 1'b0;
        fwd_stall_entry_set_o = 1'b0;
        fwd_stall_entry_o     = '0;

        case (op_i)
            MSHR_LOOKUP: begin
                for (int i = 0; i < `N_MSHR; i++) begin
                    if (flags_i[i].line_match) begin
                        hit_next_o = 1'b1;
                        idx_next_o = i[`MSHR_BITS-1:0];
                    end
                end
            end
            MSHR_PEEK_REQ: begin
                // clear unless some valid entry shares the set
                set_conflict_clr_o = 1'b1;
                for (int i = 0; i < `N_MSHR; i++) begin
                    if (!flags_i[i].valid) begin
                        idx_next_o = i[`MSHR_BITS-1:0];
                    end
                    if (flags_i[i].set_match) begin
                        set_conflict_set_o = 1'b1;
                        set_conflict_clr_o = 1'b0;
                    end
                end
            end
            MSHR_PEEK_FLUSH: begin
                // free slot only, no conflict check
                for (int i = 0; i < `N_MSHR; i++) begin
                    if (!flags_i[i].valid) begin
                        idx_next_o = i[`MSHR_BITS-1:0];
                    end
                end
            end
            MSHR_PEEK_FWD: begin
                fwd_stall_clr_o = 1'b1;
                for (int i = 0; i < `N_MSHR; i++) begin
                    if (flags_i[i].line_match) begin
                        hit_next_o = 1'b1;
                        idx_next_o = i[`MSHR_BITS-1:0];
                        // stall on any match the state cannot absorb
                        if (!flags_i[i].fwd_ok) begin
                            fwd_stall_set_o = 1'b1;
                            fwd_stall_clr_o = 1'b0;
                        end
                    end
                end
                // name the entry to wait on
                fwd_stall_entry_set_o = fwd_stall_set_o;
                if (fwd_stall_set_o) begin
                    fwd_stall_entry_o = idx_next_o;
                end
            end
            default: begin
                hit_next_o = 1'b0;
            end
        endcase
    end

    // index and hit hold through idle cycles
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            idx_o <= '0;
            hit_o <= 1'b0;
        end else if (op_i != MSHR_IDLE) begin
            idx_o <= idx_next_o;
            hit_o <= hit_next_o;
        end
    end

    // ownership or atomic outstanding anywhere
    always_comb begin
        write_pending_o = 1'b0;
        for (int i = 0; i < `N_MSHR; i++) begin
            write_pending_o = write_pending_o | flags_i[i].wr_pending;
        end
    end

    a_pairs_excl: assert property (@(posedge clk) disable iff (!rst)
        !(set_conflict_set_o && set_conflict_clr_o) && !(fwd_stall_set_o && fwd_stall_clr_o));

    // index is fed back as the write select of every entry
    a_idx_known: assert property (@(posedge clk) disable iff (!rst)
        !$isunknown(idx_o));

endmodule

// ==== mshr/mshr_top.sv ====
`timescale 1ns/1ns
`include "l2_macros.svh"

module mshr_top (
    input  logic                  clk,
    input  logic                  rst,
    input  coh_pkg::mshr_op_t     op_i,
    input  coh_pkg::fwd_msg_t     fwd_msg_i,
    input  logic                  add_entry_i,
    input  logic                  upd_state_i,
    input  logic                  upd_line_i,
    input  logic                  upd_tag_i,
    input  logic                  upd_mask_i,
    input  mshr_pkg::req_addr_t   req_addr_i,
    input  mshr_pkg::line_addr_t  line_addr_i,
    input  mshr_pkg::mshr_wr_t    wr_data_i,
    output logic                  hit_next_o,
    output logic                  hit_o,
    output logic [`MSHR_BITS-1:0] idx_next_o,
    output logic [`MSHR_BITS-1:0] idx_o,
    output logic                  set_conflict_set_o,
    output logic                  set_conflict_clr_o,
    output logic                  fwd_stall_set_o,
    output logic                  fwd_stall_clr_o,
    output logic                  fwd_stall_entry_set_o,
    output logic [`MSHR_BITS-1:0] fwd_stall_entry_o,
    output logic                  write_pending_o,
    output mshr_pkg::mshr_entry_t entries_o [`N_MSHR]
);
    import mshr_pkg::*;

    // status of every slot, gathered for the search
    entry_flags_t flags [`N_MSHR];

    // one entry per slot, write index comes back from the search
    for (genvar g = 0; g < `N_MSHR; g++) begin : g_entry
        mshr_entry #(
            .ENTRY_ID(g)
        ) u_entry (
            .clk         (clk),
            .rst         (rst),
            .add_entry_i (add_entry_i),
            .upd_state_i (upd_state_i),
            .upd_line_i  (upd_line_i),
            .upd_tag_i   (upd_tag_i),
            .upd_mask_i  (upd_mask_i),
            .wr_idx_i    (idx_o),
            .req_addr_i  (req_addr_i),
            .wr_data_i   (wr_data_i),
            .line_addr_i (line_addr_i),
            .fwd_msg_i   (fwd_msg_i),
            .entry_o     (entries_o[g]),
            .flags_o     (flags[g])
        );
    end

    mshr_search u_search (
        .clk                   (clk),
        .rst                   (rst),
        .op_i                  (op_i),
        .flags_i               (flags),
        .hit_next_o            (hit_next_o),
        .hit_o                 (hit_o),
        .idx_next_o            (idx_next_o),
        .idx_o                 (idx_o),
        .set_conflict_set_o    (set_conflict_set_o),
        .set_conflict_clr_o    (set_conflict_clr_o),
        .fwd_stall_set_o       (fwd_stall_set_o),
        .fwd_stall_clr_o       (fwd_stall_clr_o),
        .fwd_stall_entry_set_o (fwd_stall_entry_set_o),
        .fwd_stall_entry_o     (fwd_stall_entry_o),
        .write_pending_o       (write_pending_o)
    );

endmodule

// ==== test/tb_mshr.sv ====
`timescale 1ns/1ns
`include "l2_macros.svh"

module tb_mshr;
    import coh_pkg::*;
    import mshr_pkg::*;

    localparam int unsigned SEED           = 13973;
    localparam int unsigned N_CYCLES       = 2000;
    localparam int unsigned TIMEOUT_CYCLES = N_CYCLES + 100;

    logic clk;
    logic rst;
    mshr_op_t op;
    fwd_msg_t fwd_msg;
    logic add_entry, upd_state, upd_line, upd_tag, upd_mask;
    req_addr_t req_addr;
    line_addr_t line_addr;
    mshr_wr_t wr_data;
    logic hit_next, hit, sc_set, sc_clr, fs_set, fs_clr, fse_set, wr_pend;
    logic [`MSHR_BITS-1:0] idx_next, idx, fse;
    mshr_entry_t entries [`N_MSHR];

    // reference state
    mshr_entry_t model_entries [`N_MSHR];
    logic [`MSHR_BITS-1:0] model_idx;
    logic model_hit;
    // expected comb outputs for the current inputs
    logic exp_hit_next, exp_sc_set, exp_sc_clr, exp_fs_set, exp_fs_clr, exp_wp;
    logic [`MSHR_BITS-1:0] exp_idx_next, exp_fse;
    // how often the interesting cases came up
    int unsigned n_lookup_hits, n_conflicts, n_stalls, n_fwd_clears, n_wr_pend;

    mshr_top u_mshr_top (
        .clk(clk), .rst(rst), .op_i(op), .fwd_msg_i(fwd_msg),
        .add_entry_i(add_entry), .upd_state_i(upd_state), .upd_line_i(upd_line),
        .upd_tag_i(upd_tag), .upd_mask_i(upd_mask),
        .req_addr_i(req_addr), .line_addr_i(line_addr), .wr_data_i(wr_data),
        .hit_next_o(hit_next), .hit_o(hit), .idx_next_o(idx_next), .idx_o(idx),
        .set_conflict_set_o(sc_set), .set_conflict_clr_o(sc_clr),
        .fwd_stall_set_o(fs_set), .fwd_stall_clr_o(fs_clr),
        .fwd_stall_entry_set_o(fse_set), .fwd_stall_entry_o(fse),
        .write_pending_o(wr_pend), .entries_o(entries)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // forward goes through on invalidate, or on a revoke or data request in RI
    function automatic logic forward_allowed(fwd_msg_t msg, spx_state_t st);
        if (msg == FWD_INV) begin
            return 1'b1;
        end
        if (msg inside {FWD_RVK_O, FWD_REQ_S, FWD_REQ_ODATA}) begin
            return (st == SPX_RI);
        end
        return 1'b0;
    endfunction

    // expected search outputs from model entries and current inputs
    task automatic predict();
        logic found_line, found_free;
        found_line = 1'b0;
        found_free = 1'b0;
        exp_hit_next = 1'b0;
        exp_idx_next = '0;
        exp_sc_set = 1'b0;
        exp_fs_set = 1'b0;
        exp_fse = '0;
        exp_wp = 1'b0;
        // walk from the top slot, first qualifier wins
        for (int i = `N_MSHR - 1; i >= 0; i--) begin
            if (model_entries[i].state inside {SPX_XR, SPX_XRV, SPX_AMO}) begin
                exp_wp = 1'b1;
            end
            if (op == MSHR_LOOKUP || op == MSHR_PEEK_FWD) begin
                if (model_entries[i].state != SPX_I && model_entries[i].tag == line_addr.tag
                    && model_entries[i].set == line_addr.set) begin
                    if (!found_line) begin
                        exp_idx_next = i;
                    end
                    found_line = 1'b1;
                    if (op == MSHR_PEEK_FWD
                        && !forward_allowed(fwd_msg, model_entries[i].state)) begin
                        exp_fs_set = 1'b1;
                    end
                end
            end
            if (op == MSHR_PEEK_REQ || op == MSHR_PEEK_FLUSH) begin
                if (model_entries[i].state == SPX_I && !found_free) begin
                    found_free = 1'b1;
                    exp_idx_next = i;
                end
                if (op == MSHR_PEEK_REQ && model_entries[i].state != SPX_I
                    && model_entries[i].set == req_addr.set) begin
                    exp_sc_set = 1'b1;
                end
            end
        end
        exp_hit_next = found_line;
        exp_sc_clr = (op == MSHR_PEEK_REQ) && !exp_sc_set;
        exp_fs_clr = (op == MSHR_PEEK_FWD) && !exp_fs_set;
        if (exp_fs_set) begin
            exp_fse = exp_idx_next;
        end
    endtask

    task automatic check_outputs();
        predict();
        check_value("hit_next_o", hit_next, exp_hit_next);
        check_value("idx_next_o", idx_next, exp_idx_next);
        check_value("set_conflict_set_o", sc_set, exp_sc_set);
        check_value("set_conflict_clr_o", sc_clr, exp_sc_clr);
        check_value("fwd_stall_set_o", fs_set, exp_fs_set);
        check_value("fwd_stall_clr_o", fs_clr, exp_fs_clr);
        check_value("fwd_stall_entry_set_o", fse_set, exp_fs_set);
        check_value("fwd_stall_entry_o", fse, exp_fse);
        check_value("write_pending_o", wr_pend, exp_wp);
        check_value("hit_o", hit, model_hit);
        check_value("idx_o", idx, model_idx);
        for (int i = 0; i < `N_MSHR; i++) begin
            check_value($sformatf("entries_o[%0d]", i), entries[i], model_entries[i]);
        end
        n_lookup_hits += (op == MSHR_LOOKUP && exp_hit_next);
        n_conflicts += exp_sc_set;
        n_stalls += exp_fs_set;
        n_fwd_clears += exp_fs_clr;
        n_wr_pend += exp_wp;
    endtask

    // clock edge in the model, inputs still hold the values of this cycle
    task automatic update_model();
        int unsigned w;
        predict();
        w = model_idx;
        if (add_entry) begin
            model_entries[w].cpu_msg = wr_data.cpu_msg;
            model_entries[w].way = wr_data.way;
            model_entries[w].word = wr_data.word;
            model_entries[w].set = req_addr.set;
            model_entries[w].w_off = req_addr.w_off;
        end
        if (add_entry || upd_state) begin
            model_entries[w].state = wr_data.state;
        end
        if (add_entry || upd_line) begin
            model_entries[w].line = wr_data.line;
        end
        if (add_entry || upd_tag) begin
            model_entries[w].tag = wr_data.tag;
        end
        if (add_entry || upd_mask) begin
            model_entries[w].word_mask = wr_data.word_mask;
        end
        if (op != MSHR_IDLE) begin
            model_idx = exp_idx_next;
            model_hit = exp_hit_next;
        end
    endtask

    // small tag and set pools so matches are common
    function automatic logic [`TAG_BITS-1:0] pick_tag();
        return ($urandom_range(1, 0) == 0) ? 8'h3c : 8'ha5;
    endfunction

    function automatic logic [`SET_BITS-1:0] pick_set();
        return ($urandom_range(1, 0) == 0) ? 4'h2 : 4'h9;
    endfunction

    task automatic drive_random();
        mshr_wr_t wd;
        logic do_add;
        logic live;
        wd.cpu_msg = $urandom_range(3, 0);
        wd.way = $urandom_range(3, 0);
        wd.word = $urandom();
        // a third of writes free the slot
        if ($urandom_range(2, 0) == 0) begin
            wd.state = SPX_I;
        end else begin
            wd.state = spx_state_t'($urandom_range(6, 1));
        end
        wd.line = {$urandom(), $urandom(), $urandom(), $urandom()};
        wd.tag = pick_tag();
        wd.word_mask = $urandom_range(15, 0);
        wr_data <= wd;
        op <= mshr_op_t'($urandom_range(4, 0));
        fwd_msg <= fwd_msg_t'($urandom_range(4, 0));
        do_add = ($urandom_range(3, 0) == 0);
        // slot written at the next edge is model_idx
        // partial strobes only reach it while live, or together with an add
        live = do_add || (model_entries[model_idx].state != SPX_I);
        add_entry <= do_add;
        upd_state <= live && ($urandom_range(5, 0) == 0);
        upd_line <= live && ($urandom_range(5, 0) == 0);
        upd_tag <= live && ($urandom_range(5, 0) == 0);
        upd_mask <= live && ($urandom_range(5, 0) == 0);
        req_addr <= '{tag: pick_tag(), set: pick_set(), w_off: $urandom_range(3, 0)};
        line_addr <= '{tag: pick_tag(), set: pick_set()};
    endtask

    // run limit
    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(SEED));
        rst = 1'b0;
        op = MSHR_IDLE;
        fwd_msg = FWD_INV;
        add_entry = 1'b0;
        upd_state = 1'b0;
        upd_line = 1'b0;
        upd_tag = 1'b0;
        upd_mask = 1'b0;
        req_addr = '0;
        line_addr = '0;
        wr_data = '0;
        model_idx = '0;
        model_hit = 1'b0;
        for (int i = 0; i < `N_MSHR; i++) begin
            model_entries[i] = '0;
        end
        n_lookup_hits = 0;
        n_conflicts = 0;
        n_stalls = 0;
        n_fwd_clears = 0;
        n_wr_pend = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        // out of reset, all zero and idle
        @(negedge clk);
        for (int i = 0; i < `N_MSHR; i++) begin
            check_value($sformatf("entries_o[%0d]", i), entries[i], '0);
        end
        check_value("write_pending_o", wr_pend, 1'b0);
        check_outputs();
        for (int c = 0; c < N_CYCLES; c++) begin
            @(posedge clk);
            update_model();
            drive_random();
            @(negedge clk);
            check_outputs();
        end
        if (n_lookup_hits == 0 || n_conflicts == 0 || n_stalls == 0 || n_fwd_clears == 0
            || n_wr_pend == 0) begin
            $display("Random stimulus missed a lookup hit, conflict, stall or write pending");
            $display("Regression failed");
            $fatal(1, "coverage gap");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule
